/* all.f */
hdl/gat_dbg_pkg.sv
hdl/dbg_reg_pkg.sv
hdl/stage_handshake_monitor.sv
hdl/feat_write_watch.sv
hdl/probe_capture.sv
hdl/dbg_apb_regs.sv
hdl/gat_debug_top.sv
tb/tb_gat_debug.sv

/* Bender.yml */
package:
  name: gat_debug

sources:
  - hdl/gat_dbg_pkg.sv
  - hdl/dbg_reg_pkg.sv
  - hdl/stage_handshake_monitor.sv
  - hdl/feat_write_watch.sv
  - hdl/probe_capture.sv
  - hdl/dbg_apb_regs.sv
  - hdl/gat_debug_top.sv
  - target: test
    files:
      - tb/tb_gat_debug.sv

/* tb/tb_gat_debug.sv */
`timescale 1ns/1ps

module tb_gat_debug
  import gat_dbg_pkg::*;
  import dbg_reg_pkg::*;
();

  localparam int APB_TIMEOUT = 16;

  logic clk = 1'b0;
  logic rst_n;
  logic spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy;
  logic sm_vld, sm_rdy, aggr_vld, aggr_rdy;
  wh_addr_t                       wh_addr;
  sppe_val_t [NUM_SPPE_LANES-1:0] sppe;
  logic                           feat_ena;
  feat_addr_t                     feat_addr;
  feat_data_t                     feat_din;
  apb_addr_t                      paddr;
  logic                           psel, penable, pwrite;
  apb_data_t                      pwdata;
  apb_data_t                      prdata_o;
  logic                           pready_o, pslverr_o;
  sppe_val_t                      lane_vals [NUM_SPPE_LANES];  // last values driven

  always #5 clk = ~clk;

  gat_debug_top gat_debug_top_inst (
    .clk (clk), .rst_n (rst_n),
    .spmm_vld_i (spmm_vld), .spmm_rdy_i (spmm_rdy),
    .dmvm_vld_i (dmvm_vld), .dmvm_rdy_i (dmvm_rdy),
    .sm_vld_i (sm_vld), .sm_rdy_i (sm_rdy),
    .aggr_vld_i (aggr_vld), .aggr_rdy_i (aggr_rdy),
    .wh_addr_i (wh_addr), .sppe_i (sppe),
    .feat_ena_i (feat_ena), .feat_addr_i (feat_addr), .feat_din_i (feat_din),
    .paddr_i (paddr), .psel_i (psel), .penable_i (penable),
    .pwrite_i (pwrite), .pwdata_i (pwdata),
    .prdata_o (prdata_o), .pready_o (pready_o), .pslverr_o (pslverr_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checking and APB access
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                          output apb_data_t rdata, output logic err);
    int waited;
    @(posedge clk);  // setup phase
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);  // sample mid access phase
    waited = 0;
    while (!pready_o && waited < APB_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!pready_o) begin
      $display("APB access to 0x%h never saw pready_o", addr);
      $display("TESTBENCH FAILED");
      $fatal(1, "apb timeout");
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk);  // write lands here
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic reg_write(input apb_addr_t addr, input apb_data_t data);
    apb_data_t rdata;
    logic      err;
    apb_xfer(1'b1, addr, data, rdata, err);
    check_val($sformatf("pslverr_o on write 0x%h", addr), 32'(err), 32'h0);
  endtask

  task automatic reg_check(input apb_addr_t addr, input apb_data_t exp, input string name);
    apb_data_t rdata;
    logic      err;
    apb_xfer(1'b0, addr, 32'h0, rdata, err);
    check_val($sformatf("pslverr_o on read 0x%h", addr), 32'(err), 32'h0);
    check_val(name, rdata, exp);
  endtask

  task automatic expect_slverr(input logic wr, input apb_addr_t addr, input string what);
    apb_data_t rdata;
    logic      err;
    apb_xfer(wr, addr, 32'h0, rdata, err);
    check_val($sformatf("pslverr_o (%s)", what), 32'(err), 32'h1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // accelerator side stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bit 7 spmm_vld down to bit 0 aggr_rdy, held for a number of edges
  task automatic pulse_hs(input logic [7:0] v, input int cycles);
    @(posedge clk);
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy, sm_vld, sm_rdy, aggr_vld, aggr_rdy} <= v;
    repeat (cycles) @(posedge clk);
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy, sm_vld, sm_rdy, aggr_vld, aggr_rdy} <= 8'h00;
  endtask

  task automatic probe_cycle(input wh_addr_t addr, input logic rdy);
    @(posedge clk);
    for (int l = 0; l < NUM_SPPE_LANES; l++) begin
      lane_vals[l] = sppe_val_t'($urandom);
      sppe[l]     <= lane_vals[l];
    end
    wh_addr  <= addr;
    spmm_rdy <= rdy;
    @(posedge clk);
    spmm_rdy <= 1'b0;
  endtask

  task automatic feat_write(input feat_addr_t addr, input feat_data_t data);
    @(posedge clk);
    feat_ena  <= 1'b1;
    feat_addr <= addr;
    feat_din  <= data;
    @(posedge clk);
    feat_ena  <= 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_reset_id();
    apb_addr_t zero_regs [11] = '{REG_STAGE_FLAGS, REG_CNT_SPMM, REG_CNT_DMVM, REG_CNT_SM,
                                  REG_CNT_AGGR, REG_PROBE0_CFG, REG_PROBE0_DATA,
                                  REG_PROBE1_CFG, REG_PROBE1_DATA, REG_FEAT_STATUS,
                                  REG_FEAT_DATA};
    check_val("pready_o", 32'(pready_o), 32'h1);
    check_val("pslverr_o", 32'(pslverr_o), 32'h0);
    reg_check(REG_ID, DBG_ID_VALUE, "id");
    reg_check(REG_CONFIG, {16'h0, 8'd16, 8'd12}, "config");
    foreach (zero_regs[i]) reg_check(zero_regs[i], 32'h0, $sformatf("reg 0x%h", zero_regs[i]));
  endtask

  task automatic test_flags_counters();
    logic [7:0] exp_flags;
    int         n_xfer [4];
    exp_flags = '0;
    n_xfer    = '{5, 7, 2, 9};  // spmm, dmvm, sm, aggr
    for (int b = 7; b >= 0; b--) begin
      pulse_hs(8'(1 << b), 1);
      exp_flags[b] = 1'b1;
      reg_check(REG_STAGE_FLAGS, 32'(exp_flags), "stage_flags");
    end
    reg_check(REG_CNT_SPMM, 32'h0, "cnt_spmm");  // lone valid or ready is no transfer
    for (int s = 0; s < 4; s++) pulse_hs(8'h03 << (6 - 2 * s), n_xfer[s]);
    for (int s = 0; s < 4; s++)
      reg_check(apb_addr_t'(REG_CNT_SPMM + 4 * s), n_xfer[s], $sformatf("cnt stage %0d", s));
    reg_write(REG_CLEAR, 32'(1 << CLR_FLAGS));
    reg_check(REG_STAGE_FLAGS, 32'h0, "stage_flags");
    for (int s = 0; s < 4; s++)
      reg_check(apb_addr_t'(REG_CNT_SPMM + 4 * s), n_xfer[s], $sformatf("cnt stage %0d", s));
    pulse_hs(8'h80, 1);
    reg_write(REG_CLEAR, 32'(1 << CLR_CNT));
    for (int s = 0; s < 4; s++)
      reg_check(apb_addr_t'(REG_CNT_SPMM + 4 * s), 32'h0, $sformatf("cnt stage %0d", s));
    reg_check(REG_STAGE_FLAGS, 32'h80, "stage_flags");
  endtask

  task automatic test_probe_capture();
    wh_addr_t  addr0;
    wh_addr_t  addr1;
    lane_sel_t lane0;
    lane_sel_t lane1;
    sppe_val_t v0;
    addr0 = wh_addr_t'($urandom);
    addr1 = addr0 ^ 14'h2a5a;
    lane0 = lane_sel_t'($urandom);
    lane1 = lane0 + 4'd7;
    reg_write(REG_PROBE0_CFG, {12'h0, lane0, 2'b00, addr0});
    reg_write(REG_PROBE1_CFG, {12'h0, lane1, 2'b00, addr1});
    reg_check(REG_PROBE0_CFG, {12'h0, lane0, 2'b00, addr0}, "probe0_cfg");
    reg_check(REG_PROBE1_CFG, {12'h0, lane1, 2'b00, addr1}, "probe1_cfg");
    reg_write(REG_CLEAR, 32'(1 << CLR_PROBE));  // earlier tests hit address 0
    reg_check(REG_PROBE0_DATA, 32'h0, "probe0_data");
    reg_check(REG_PROBE1_DATA, 32'h0, "probe1_data");
    probe_cycle(addr0, 1'b0);
    reg_check(REG_PROBE0_DATA, 32'h0, "probe0_data");
    probe_cycle(addr0, 1'b1);
    v0 = lane_vals[lane0];
    reg_check(REG_PROBE0_DATA, {20'h80000, v0}, "probe0_data");
    reg_check(REG_PROBE1_DATA, 32'h0, "probe1_data");
    probe_cycle(addr1, 1'b1);
    reg_check(REG_PROBE1_DATA, {20'h80000, lane_vals[lane1]}, "probe1_data");
    reg_check(REG_PROBE0_DATA, {20'h80000, v0}, "probe0_data");
    probe_cycle(addr0, 1'b1);  // overwrite
    reg_check(REG_PROBE0_DATA, {20'h80000, lane_vals[lane0]}, "probe0_data");
    reg_write(REG_CLEAR, 32'(1 << CLR_PROBE));
    reg_check(REG_PROBE0_DATA, 32'h0, "probe0_data");
    reg_check(REG_PROBE1_DATA, 32'h0, "probe1_data");
  endtask

  task automatic test_feat_watch();
    feat_data_t last;
    feat_addr_t span_addr;
    feat_write(16'h1234, feat_data_t'($urandom));
    feat_write(FEAT_BOUNDARY - 16'd1, feat_data_t'($urandom));
    reg_check(REG_FEAT_STATUS, 32'h8000_0000, "feat_status");
    reg_check(REG_FEAT_DATA, 32'h0, "feat_data");
    span_addr = FEAT_BOUNDARY + feat_addr_t'($urandom % (32'h1_0000 - 32'd43328));
    feat_write(FEAT_BOUNDARY, feat_data_t'($urandom));
    feat_write(span_addr, feat_data_t'($urandom));
    last = feat_data_t'($urandom);
    feat_write(16'hffff, last);
    reg_check(REG_FEAT_STATUS, 32'hc000_0003, "feat_status");
    reg_check(REG_FEAT_DATA, last, "feat_data");
    reg_write(REG_CLEAR, 32'(1 << CLR_FEAT));
    reg_check(REG_FEAT_STATUS, 32'h0, "feat_status");
    reg_check(REG_FEAT_DATA, 32'h0, "feat_data");
  endtask

  task automatic test_apb_errors();
    pulse_hs(8'hff, 1);
    reg_check(REG_STAGE_FLAGS, 32'hff, "stage_flags");
    expect_slverr(1'b0, 8'h38, "read of unmapped offset");
    expect_slverr(1'b1, REG_STAGE_FLAGS, "write to stage flags");
    reg_check(REG_STAGE_FLAGS, 32'hff, "stage_flags");
    expect_slverr(1'b0, REG_CLEAR, "read of clear register");
  endtask

  initial begin
    int unsigned seed_init;
    seed_init = $urandom(32'hf75c3b46);
    rst_n    <= 1'b0;
    {spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy, sm_vld, sm_rdy, aggr_vld, aggr_rdy} <= 8'h00;
    wh_addr  <= '0;
    sppe     <= '0;
    feat_ena <= 1'b0;
    feat_addr <= '0;
    feat_din <= '0;
    paddr    <= '0;
    psel     <= 1'b0;
    penable  <= 1'b0;
    pwrite   <= 1'b0;
    pwdata   <= '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_id();
    test_flags_counters();
    test_probe_capture();
    test_feat_watch();
    test_apb_errors();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* hdl/gat_debug_top.sv */
`timescale 1ns/1ps

module gat_debug_top
  import gat_dbg_pkg::*;
  import dbg_reg_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           spmm_vld_i,
  input  logic                           spmm_rdy_i,
  input  logic                           dmvm_vld_i,
  input  logic                           dmvm_rdy_i,
  input  logic                           sm_vld_i,
  input  logic                           sm_rdy_i,
  input  logic                           aggr_vld_i,
  input  logic                           aggr_rdy_i,
  input  wh_addr_t                       wh_addr_i,
  input  sppe_val_t [NUM_SPPE_LANES-1:0] sppe_i,
  input  logic                           feat_ena_i,
  input  feat_addr_t                     feat_addr_i,
  input  feat_data_t                     feat_din_i,
  input  apb_addr_t                      paddr_i,
  input  logic                           psel_i,
  input  logic                           penable_i,
  input  logic                           pwrite_i,
  input  apb_data_t                      pwdata_i,
  output apb_data_t                      prdata_o,
  output logic                           pready_o,
  output logic                           pslverr_o
);

  logic [2*NUM_STAGES-1:0] stage_flags;
  dbg_cnt_t                cnt_spmm;
  dbg_cnt_t                cnt_dmvm;
  dbg_cnt_t                cnt_sm;
  dbg_cnt_t                cnt_aggr;
  logic                    ena_seen;
  logic                    high_seen;
  logic [FEAT_CNT_W-1:0]   high_cnt;
  feat_data_t              high_data;
  logic                    probe0_hit;
  logic                    probe1_hit;
  sppe_val_t               probe0_val;
  sppe_val_t               probe1_val;
  wh_addr_t                probe0_addr;
  wh_addr_t                probe1_addr;
  lane_sel_t               probe0_lane;
  lane_sel_t               probe1_lane;
  logic                    clr_flags;
  logic                    clr_cnt;
  logic                    clr_probe;
  logic                    clr_feat;

  stage_handshake_monitor stage_handshake_monitor_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .spmm_vld_i    (spmm_vld_i),
    .spmm_rdy_i    (spmm_rdy_i),
    .dmvm_vld_i    (dmvm_vld_i),
    .dmvm_rdy_i    (dmvm_rdy_i),
    .sm_vld_i      (sm_vld_i),
    .sm_rdy_i      (sm_rdy_i),
    .aggr_vld_i    (aggr_vld_i),
    .aggr_rdy_i    (aggr_rdy_i),
    .clr_flags_i   (clr_flags),
    .clr_cnt_i     (clr_cnt),
    .stage_flags_o (stage_flags),
    .cnt_spmm_o    (cnt_spmm),
    .cnt_dmvm_o    (cnt_dmvm),
    .cnt_sm_o      (cnt_sm),
    .cnt_aggr_o    (cnt_aggr)
  );

  feat_write_watch feat_write_watch_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .feat_ena_i  (feat_ena_i),
    .feat_addr_i (feat_addr_i),
    .feat_din_i  (feat_din_i),
    .clr_feat_i  (clr_feat),
    .ena_seen_o  (ena_seen),
    .high_seen_o (high_seen),
    .high_cnt_o  (high_cnt),
    .high_data_o (high_data)
  );

  probe_capture probe_capture_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .spmm_rdy_i    (spmm_rdy_i),
    .wh_addr_i     (wh_addr_i),
    .sppe_i        (sppe_i),
    .probe0_addr_i (probe0_addr),
    .probe1_addr_i (probe1_addr),
    .probe0_lane_i (probe0_lane),
    .probe1_lane_i (probe1_lane),
    .clr_probe_i   (clr_probe),
    .probe0_hit_o  (probe0_hit),
    .probe1_hit_o  (probe1_hit),
    .probe0_val_o  (probe0_val),
    .probe1_val_o  (probe1_val)
  );

  dbg_apb_regs dbg_apb_regs_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .paddr_i       (paddr_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .pwdata_i      (pwdata_i),
    .stage_flags_i (stage_flags),
    .cnt_spmm_i    (cnt_spmm),
    .cnt_dmvm_i    (cnt_dmvm),
    .cnt_sm_i      (cnt_sm),
    .cnt_aggr_i    (cnt_aggr),
    .ena_seen_i    (ena_seen),
    .high_seen_i   (high_seen),
    .high_cnt_i    (high_cnt),
    .high_data_i   (high_data),
    .probe0_hit_i  (probe0_hit),
    .probe1_hit_i  (probe1_hit),
    .probe0_val_i  (probe0_val),
    .probe1_val_i  (probe1_val),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .clr_flags_o   (clr_flags),
    .clr_cnt_o     (clr_cnt),
    .clr_probe_o   (clr_probe),
    .clr_feat_o    (clr_feat),
    .probe0_addr_o (probe0_addr),
    .probe0_lane_o (probe0_lane),
    .probe1_addr_o (probe1_addr),
    .probe1_lane_o (probe1_lane)
  );

endmodule

/* hdl/dbg_apb_regs.sv */
`timescale 1ns/1ps

module dbg_apb_regs
  import gat_dbg_pkg::*;
  import dbg_reg_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  apb_addr_t               paddr_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  apb_data_t               pwdata_i,
  input  logic [2*NUM_STAGES-1:0] stage_flags_i,
  input  dbg_cnt_t                cnt_spmm_i,
  input  dbg_cnt_t                cnt_dmvm_i,
  input  dbg_cnt_t                cnt_sm_i,
  input  dbg_cnt_t                cnt_aggr_i,
  input  logic                    ena_seen_i,
  input  logic                    high_seen_i,
  input  logic [FEAT_CNT_W-1:0]   high_cnt_i,
  input  feat_data_t              high_data_i,
  input  logic                    probe0_hit_i,
  input  logic                    probe1_hit_i,
  input  sppe_val_t               probe0_val_i,
  input  sppe_val_t               probe1_val_i,
  output apb_data_t               prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  output logic                    clr_flags_o,
  output logic                    clr_cnt_o,
  output logic                    clr_probe_o,
  output logic                    clr_feat_o,
  output wh_addr_t                probe0_addr_o,
  output lane_sel_t               probe0_lane_o,
  output wh_addr_t                probe1_addr_o,
  output lane_sel_t               probe1_lane_o
);

  apb_state_t apb_state;
  apb_state_t apb_state_nxt;
  logic       access;
  logic       addr_ok;
  logic       rd_ok;
  logic       wr_ok;
  logic       err;
  logic       wr_en;
  apb_data_t  rd_data;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB phase tracking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    if (!psel_i) apb_state_nxt = IDLE;
    else if (!penable_i) apb_state_nxt = SETUP;
    else apb_state_nxt = ACCESS;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) apb_state <= IDLE;
    else apb_state <= apb_state_nxt;
  end

  assign access   = psel_i && penable_i && (apb_state == SETUP);
  assign pready_o = 1'b1;  // no wait states

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode and read mux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    rd_data = '0;
    addr_ok = 1'b1;
    rd_ok   = 1'b1;
    wr_ok   = 1'b0;
    case (paddr_i)
      REG_ID:          rd_data = DBG_ID_VALUE;
      REG_CONFIG: begin
        rd_data[7:0]  = 8'(NUM_SPARSE_DATA);
        rd_data[15:8] = 8'(NUM_SPPE_LANES);
      end
      REG_STAGE_FLAGS: rd_data[2*NUM_STAGES-1:0] = stage_flags_i;
      REG_CLEAR: begin
        rd_ok = 1'b0;
        wr_ok = 1'b1;
      end
      REG_CNT_SPMM:    rd_data = cnt_spmm_i;
      REG_CNT_DMVM:    rd_data = cnt_dmvm_i;
      REG_CNT_SM:      rd_data = cnt_sm_i;
      REG_CNT_AGGR:    rd_data = cnt_aggr_i;
      REG_PROBE0_CFG: begin
        rd_data[WH_ADDR_W-1:0]                 = probe0_addr_o;
        rd_data[CFG_LANE_LSB +: LANE_SEL_W]    = probe0_lane_o;
        wr_ok                                  = 1'b1;
      end
      REG_PROBE0_DATA: begin
        rd_data[HIT_BIT]    = probe0_hit_i;
        rd_data[SPPE_W-1:0] = probe0_val_i;
      end
      REG_PROBE1_CFG: begin
        rd_data[WH_ADDR_W-1:0]                 = probe1_addr_o;
        rd_data[CFG_LANE_LSB +: LANE_SEL_W]    = probe1_lane_o;
        wr_ok                                  = 1'b1;
      end
      REG_PROBE1_DATA: begin
        rd_data[HIT_BIT]    = probe1_hit_i;
        rd_data[SPPE_W-1:0] = probe1_val_i;
      end
      REG_FEAT_STATUS: begin
        rd_data[ENA_SEEN_BIT]     = ena_seen_i;
        rd_data[HIGH_SEEN_BIT]    = high_seen_i;
        rd_data[FEAT_CNT_W-1:0]   = high_cnt_i;
      end
      REG_FEAT_DATA:   rd_data = high_data_i;
      default:         addr_ok = 1'b0;
    endcase
  end

  assign err       = !addr_ok || (pwrite_i ? !wr_ok : !rd_ok);
  assign wr_en     = access && pwrite_i && !err;
  assign pslverr_o = access && err;
  assign prdata_o  = (access && !pwrite_i && !err) ? rd_data : '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // probe config and clear pulses
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clr_flags_o   <= 1'b0;
      clr_cnt_o     <= 1'b0;
      clr_probe_o   <= 1'b0;
      clr_feat_o    <= 1'b0;
      probe0_addr_o <= '0;
      probe0_lane_o <= '0;
      probe1_addr_o <= '0;
      probe1_lane_o <= '0;
    end else begin
      // single cycle pulses
      clr_flags_o <= wr_en && (paddr_i == REG_CLEAR) && pwdata_i[CLR_FLAGS];
      clr_cnt_o   <= wr_en && (paddr_i == REG_CLEAR) && pwdata_i[CLR_CNT];
      clr_probe_o <= wr_en && (paddr_i == REG_CLEAR) && pwdata_i[CLR_PROBE];
      clr_feat_o  <= wr_en && (paddr_i == REG_CLEAR) && pwdata_i[CLR_FEAT];
      if (wr_en && (paddr_i == REG_PROBE0_CFG)) begin
        probe0_addr_o <= pwdata_i[WH_ADDR_W-1:0];
        probe0_lane_o <= pwdata_i[CFG_LANE_LSB +: LANE_SEL_W];
      end
      if (wr_en && (paddr_i == REG_PROBE1_CFG)) begin
        probe1_addr_o <= pwdata_i[WH_ADDR_W-1:0];
        probe1_lane_o <= pwdata_i[CFG_LANE_LSB +: LANE_SEL_W];
      end
    end
  end

endmodule

/* hdl/probe_capture.sv */
`timescale 1ns/1ps

module probe_capture
  import gat_dbg_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           spmm_rdy_i,
  input  wh_addr_t                       wh_addr_i,
  input  sppe_val_t [NUM_SPPE_LANES-1:0] sppe_i,
  input  wh_addr_t                       probe0_addr_i,
  input  wh_addr_t                       probe1_addr_i,
  input  lane_sel_t                      probe0_lane_i,
  input  lane_sel_t                      probe1_lane_i,
  input  logic                           clr_probe_i,
  output logic                           probe0_hit_o,
  output logic                           probe1_hit_o,
  output sppe_val_t                      probe0_val_o,
  output sppe_val_t                      probe1_val_o
);

  wh_addr_t              watch_addr [NUM_PROBES];
  lane_sel_t             watch_lane [NUM_PROBES];
  logic [NUM_PROBES-1:0] match;
  logic [NUM_PROBES-1:0] hit_q;
  sppe_val_t             val_q [NUM_PROBES];

  assign watch_addr[0] = probe0_addr_i;
  assign watch_addr[1] = probe1_addr_i;
  assign watch_lane[0] = probe0_lane_i;
  assign watch_lane[1] = probe1_lane_i;

  // only a real read of the weight buffer counts
  always_comb begin
    for (int p = 0; p < NUM_PROBES; p++) begin
      match[p] = spmm_rdy_i && (wh_addr_i == watch_addr[p]);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // capture slots
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hit_q <= '0;
      val_q <= '{default: '0};
    end else begin
      for (int p = 0; p < NUM_PROBES; p++) begin
        if (clr_probe_i) begin
          hit_q[p] <= 1'b0;
          val_q[p] <= '0;
        end else if (match[p]) begin
          hit_q[p] <= 1'b1;
          val_q[p] <= sppe_i[watch_lane[p]];  // later match overwrites
        end
      end
    end
  end

  assign probe0_hit_o = hit_q[0];
  assign probe1_hit_o = hit_q[1];
  assign probe0_val_o = val_q[0];
  assign probe1_val_o = val_q[1];

endmodule

/* hdl/feat_write_watch.sv */
`timescale 1ns/1ps

module feat_write_watch
  import gat_dbg_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  feat_ena_i,
  input  feat_addr_t            feat_addr_i,
  input  feat_data_t            feat_din_i,
  input  logic                  clr_feat_i,
  output logic                  ena_seen_o,
  output logic                  high_seen_o,
  output logic [FEAT_CNT_W-1:0] high_cnt_o,
  output feat_data_t            high_data_o
);

  logic high_wr;

  // write into the upper region
  assign high_wr = feat_ena_i && (feat_addr_i >= FEAT_BOUNDARY);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ena_seen_o  <= 1'b0;
      high_seen_o <= 1'b0;
      high_cnt_o  <= '0;
      high_data_o <= '0;
    end else if (clr_feat_i) begin
      ena_seen_o  <= 1'b0;
      high_seen_o <= 1'b0;
      high_cnt_o  <= '0;
      high_data_o <= '0;
    end else begin
      if (feat_ena_i) begin
        ena_seen_o <= 1'b1;
      end
      if (high_wr) begin
        high_seen_o <= 1'b1;
        high_cnt_o  <= high_cnt_o + 1'b1;  // wraps
        high_data_o <= feat_din_i;         // last one kept
      end
    end
  end

endmodule

/* hdl/stage_handshake_monitor.sv */
`timescale 1ns/1ps

module stage_handshake_monitor
  import gat_dbg_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    spmm_vld_i,
  input  logic                    spmm_rdy_i,
  input  logic                    dmvm_vld_i,
  input  logic                    dmvm_rdy_i,
  input  logic                    sm_vld_i,
  input  logic                    sm_rdy_i,
  input  logic                    aggr_vld_i,
  input  logic                    aggr_rdy_i,
  input  logic                    clr_flags_i,
  input  logic                    clr_cnt_i,
  output logic [2*NUM_STAGES-1:0] stage_flags_o,
  output dbg_cnt_t                cnt_spmm_o,
  output dbg_cnt_t                cnt_dmvm_o,
  output dbg_cnt_t                cnt_sm_o,
  output dbg_cnt_t                cnt_aggr_o
);

  logic [2*NUM_STAGES-1:0] flags_in;
  logic [2*NUM_STAGES-1:0] flags_q;
  logic [NUM_STAGES-1:0]   xfer;
  dbg_cnt_t                cnt_q [NUM_STAGES];

  // spmm_vld on bit 7 down to aggr_rdy on bit 0
  assign flags_in = {spmm_vld_i, spmm_rdy_i, dmvm_vld_i, dmvm_rdy_i,
                     sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i};

  // index 3 is spmm, index 0 is aggr
  assign xfer = {spmm_vld_i & spmm_rdy_i,
                 dmvm_vld_i & dmvm_rdy_i,
                 sm_vld_i & sm_rdy_i,
                 aggr_vld_i & aggr_rdy_i};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sticky flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else if (clr_flags_i) begin
      flags_q <= '0;  // clear wins over new events
    end else begin
      flags_q <= flags_q | flags_in;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transfer counters, wrap at 2^32
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '{default: '0};
    end else begin
      for (int s = 0; s < NUM_STAGES; s++) begin
        if (clr_cnt_i) begin
          cnt_q[s] <= '0;
        end else if (xfer[s]) begin
          cnt_q[s] <= cnt_q[s] + 1'b1;
        end
      end
    end
  end

  assign stage_flags_o = flags_q;
  assign cnt_spmm_o    = cnt_q[3];
  assign cnt_dmvm_o    = cnt_q[2];
  assign cnt_sm_o      = cnt_q[1];
  assign cnt_aggr_o    = cnt_q[0];

endmodule

/* hdl/dbg_reg_pkg.sv */
package dbg_reg_pkg;

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  localparam apb_data_t DBG_ID_VALUE = 32'h6A7D_0100;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam apb_addr_t REG_ID          = 8'h00;
  localparam apb_addr_t REG_CONFIG      = 8'h04;
  localparam apb_addr_t REG_STAGE_FLAGS = 8'h08;
  localparam apb_addr_t REG_CLEAR       = 8'h0C;  // write only
  localparam apb_addr_t REG_CNT_SPMM    = 8'h10;
  localparam apb_addr_t REG_CNT_DMVM    = 8'h14;
  localparam apb_addr_t REG_CNT_SM      = 8'h18;
  localparam apb_addr_t REG_CNT_AGGR    = 8'h1C;
  localparam apb_addr_t REG_PROBE0_CFG  = 8'h20;
  localparam apb_addr_t REG_PROBE0_DATA = 8'h24;
  localparam apb_addr_t REG_PROBE1_CFG  = 8'h28;
  localparam apb_addr_t REG_PROBE1_DATA = 8'h2C;
  localparam apb_addr_t REG_FEAT_STATUS = 8'h30;
  localparam apb_addr_t REG_FEAT_DATA   = 8'h34;

  // bits in REG_CLEAR
  localparam int CLR_FLAGS = 0;
  localparam int CLR_CNT   = 1;
  localparam int CLR_PROBE = 2;
  localparam int CLR_FEAT  = 3;

  // field positions
  localparam int CFG_LANE_LSB  = 16;
  localparam int HIT_BIT       = 31;
  localparam int ENA_SEEN_BIT  = 31;
  localparam int HIGH_SEEN_BIT = 30;

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apb_state_t;

endpackage

/* hdl/gat_dbg_pkg.sv */
package gat_dbg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // accelerator geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int NUM_STAGES      = 4;  // spmm, dmvm, sm, aggr
  localparam int NUM_SPPE_LANES  = 16;
  localparam int NUM_PROBES      = 2;
  localparam int NUM_SPARSE_DATA = 12;

  localparam int SPPE_W      = 12;
  localparam int WH_ADDR_W   = 14;
  localparam int FEAT_ADDR_W = 16;
  localparam int FEAT_DATA_W = 32;
  localparam int LANE_SEL_W  = 4;
  localparam int CNT_W       = 32;
  localparam int FEAT_CNT_W  = 16;

  typedef logic [SPPE_W-1:0]      sppe_val_t;
  typedef logic [WH_ADDR_W-1:0]   wh_addr_t;
  typedef logic [FEAT_ADDR_W-1:0] feat_addr_t;
  typedef logic [FEAT_DATA_W-1:0] feat_data_t;
  typedef logic [LANE_SEL_W-1:0]  lane_sel_t;
  typedef logic [CNT_W-1:0]       dbg_cnt_t;

  // start of the region past the node features
  localparam feat_addr_t FEAT_BOUNDARY = 16'd43328;

endpackage
